//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_rob_top
FILELIST = rob.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- rob.f
rob_pkg.sv
rob_dispatch.sv
rob_entry_table.sv
rob_retire.sv
rob_top.sv
rob_properties.sv
rob_checker.sv
tb_rob_top.sv

//--- rob_checker.sv
//////////////////////////////////////////////////
// reorder buffer checker
// program order model of the entries
// reference retire rule and per cycle compare
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rob_checker
(
	input  logic                          clock,
	input  logic                          reset,
	input  logic [1:0]                    dispatch_num,
	input  logic [rob_pkg::ar_width-1:0]  dest_ar0,
	input  logic [rob_pkg::ar_width-1:0]  dest_ar1,
	input  logic [rob_pkg::tag_width-1:0] new_tag0,
	input  logic [rob_pkg::tag_width-1:0] new_tag1,
	input  logic [rob_pkg::tag_width-1:0] old_tag0,
	input  logic [rob_pkg::tag_width-1:0] old_tag1,
	input  logic                          valid_inst0,
	input  logic                          valid_inst1,
	input  logic                          halt0,
	input  logic                          halt1,
	input  logic                          store0,
	input  logic                          store1,
	input  logic [rob_pkg::cdb_lanes-1:0] cdb_valid,
	input  logic [rob_pkg::tag_width-1:0] cdb_tag0,
	input  logic [rob_pkg::tag_width-1:0] cdb_tag1,
	input  logic                          cdb_exception0,
	input  logic                          cdb_exception1,
	input  logic [1:0]                    capacity,
	input  logic [1:0]                    retire_num,
	input  logic [rob_pkg::ar_width-1:0]  retire_ar0,
	input  logic [rob_pkg::ar_width-1:0]  retire_ar1,
	input  logic [rob_pkg::tag_width-1:0] retire_tag0,
	input  logic [rob_pkg::tag_width-1:0] retire_tag1,
	input  logic [rob_pkg::tag_width-1:0] retire_told0,
	input  logic [rob_pkg::tag_width-1:0] retire_told1,
	input  logic                          retire_store0,
	input  logic                          retire_store1,
	input  logic                          retire_exception,
	input  logic                          retire_halt,
	input  logic                          flush,
	output int                            error_count,
	output int                            check_count
);

	typedef struct packed
	{
		logic                          halt;
		logic                          store;
		logic                          ready;
		logic                          exc;
		logic [rob_pkg::ar_width-1:0]  ar;
		logic [rob_pkg::tag_width-1:0] tag;
		logic [rob_pkg::tag_width-1:0] told;
	} entry_t;

	entry_t model [$];  // oldest first

	function automatic rob_pkg::retire_decision_t retire_rule(input entry_t first,
		input entry_t second, input int avail, output logic exp_exc, output logic exp_halt);
		logic                      r0;
		logic                      r1;
		rob_pkg::retire_decision_t d;
		r0 = (avail > 0) && first.ready;
		r1 = (avail > 1) && second.ready;
		if (r0 && r1 && !first.exc && !(first.store && second.store))
			d = rob_pkg::retire_two;
		else if (r0)
			d = rob_pkg::retire_one;
		else
			d = rob_pkg::retire_none;
		exp_exc  = (d != rob_pkg::retire_none && first.exc)
			|| (d == rob_pkg::retire_two && second.exc);
		exp_halt = (d != rob_pkg::retire_none && first.halt)
			|| (d == rob_pkg::retire_two && second.halt);
		return d;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			$display("** Error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////
	// compare, then step the model
	//////////////////////////////////////////////////

	always @(posedge clock)
	begin
		entry_t                    e0;
		entry_t                    e1;
		rob_pkg::retire_decision_t d;
		logic                      ex;
		logic                      hl;
		int                        n;
		int                        free;
		if (reset)
		begin
			model.delete();
			error_count = 0;
			check_count = 0;
		end
		else
		begin
			e0   = (model.size() > 0) ? model[0] : '0;
			e1   = (model.size() > 1) ? model[1] : '0;
			d    = retire_rule(e0, e1, model.size(), ex, hl);
			n    = int'(d);
			free = rob_pkg::rob_depth - model.size();
			compare("capacity", (free >= 2) ? 2 : free, capacity);
			compare("retire_num", n, retire_num);
			compare("retire_exception", ex, retire_exception);
			compare("retire_halt", hl, retire_halt);
			compare("flush", ex, flush);
			if (n >= 1)
			begin
				compare("retire_ar0", e0.ar, retire_ar0);
				compare("retire_tag0", e0.tag, retire_tag0);
				compare("retire_told0", e0.told, retire_told0);
				compare("retire_store0", e0.store, retire_store0);
			end
			if (n == 2)
			begin
				compare("retire_ar1", e1.ar, retire_ar1);
				compare("retire_tag1", e1.tag, retire_tag1);
				compare("retire_told1", e1.told, retire_told1);
				compare("retire_store1", e1.store, retire_store1);
			end
			if (ex)
				model.delete();  // exception empties everything, dispatch included
			else
			begin
				repeat (n) void'(model.pop_front());
				foreach (model[i])
				begin
					if (cdb_valid[0] && model[i].tag == cdb_tag0)
					begin
						model[i].ready = 1'b1;
						model[i].exc   = cdb_exception0;
					end
					if (cdb_valid[1] && model[i].tag == cdb_tag1)
					begin
						model[i].ready = 1'b1;
						model[i].exc   = cdb_exception1;  // lane 1 wins
					end
				end
				if (dispatch_num >= 2'd1)
					model.push_back({halt0, store0, ~valid_inst0 | halt0, 1'b0,
						dest_ar0, new_tag0, old_tag0});
				if (dispatch_num == 2'd2)
					model.push_back({halt1, store1, ~valid_inst1 | halt1, 1'b0,
						dest_ar1, new_tag1, old_tag1});
			end
		end
	end

endmodule

//--- rob_dispatch.sv
//////////////////////////////////////////////////
// reorder buffer dispatch side
// tail pointer and occupancy count
// free space report to the decode stage
// write strobes and indices for the entry table
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rob_dispatch
(
	input  logic                                clock,
	input  logic                                reset,
	input  logic [1:0]                          dispatch_num,
	input  logic [1:0]                          retire_num,
	input  logic                                flush,
	input  logic [rob_pkg::rob_index_width-1:0] head,
	output logic [1:0]                          capacity,
	output logic                                write_enable0,
	output logic                                write_enable1,
	output logic [rob_pkg::rob_index_width-1:0] write_index0,
	output logic [rob_pkg::rob_index_width-1:0] write_index1
);

	logic [rob_pkg::rob_index_width-1:0] tail;
	logic [rob_pkg::count_width-1:0]     count;
	logic [rob_pkg::count_width-1:0]     free_entries;
	logic [rob_pkg::count_width-1:0]     count_next;

	//////////////////////////////////////////////////
	// capacity
	//////////////////////////////////////////////////

	assign free_entries = rob_pkg::count_width'(rob_pkg::rob_depth) - count;

	always_comb
	begin
		if (free_entries >= rob_pkg::count_width'(rob_pkg::dispatch_width))
			capacity = 2'(rob_pkg::dispatch_width);  // plenty of room
		else
			capacity = free_entries[1:0];  // 0 or 1 left
	end

	//////////////////////////////////////////////////
	// slot placement
	//////////////////////////////////////////////////

	assign write_enable0 = (dispatch_num != 2'd0);
	assign write_enable1 = (dispatch_num == 2'd2);
	assign write_index0  = tail;
	assign write_index1  = tail + 1'b1;  // wraps at rob_depth

	assign count_next = count + rob_pkg::count_width'(dispatch_num)
		- rob_pkg::count_width'(retire_num);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail  <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			// buffer empties, tail lands on the new head
			tail  <= head + rob_pkg::rob_index_width'(retire_num);
			count <= '0;
		end
		else
		begin
			tail  <= tail + rob_pkg::rob_index_width'(dispatch_num);
			count <= count_next;
		end
	end

endmodule

//--- rob_entry_table.sv
//////////////////////////////////////////////////
// reorder buffer entry storage
// per entry state written at dispatch
// completion tag match on the broadcast lanes
// release of retired entries and full flush
// head and head+1 read ports for retire
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rob_entry_table
(
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                write_enable0,
	input  logic                                write_enable1,
	input  logic [rob_pkg::rob_index_width-1:0] write_index0,
	input  logic [rob_pkg::rob_index_width-1:0] write_index1,
	input  logic [rob_pkg::ar_width-1:0]        dest_ar0,
	input  logic [rob_pkg::ar_width-1:0]        dest_ar1,
	input  logic [rob_pkg::tag_width-1:0]       new_tag0,
	input  logic [rob_pkg::tag_width-1:0]       new_tag1,
	input  logic [rob_pkg::tag_width-1:0]       old_tag0,
	input  logic [rob_pkg::tag_width-1:0]       old_tag1,
	input  logic                                valid_inst0,
	input  logic                                valid_inst1,
	input  logic                                halt0,
	input  logic                                halt1,
	input  logic                                store0,
	input  logic                                store1,
	input  logic [rob_pkg::cdb_lanes-1:0]       cdb_valid,
	input  logic [rob_pkg::tag_width-1:0]       cdb_tag0,
	input  logic [rob_pkg::tag_width-1:0]       cdb_tag1,
	input  logic                                cdb_exception0,
	input  logic                                cdb_exception1,
	input  logic [rob_pkg::rob_index_width-1:0] head,
	input  logic [1:0]                          retire_num,
	input  logic                                flush,
	output logic                                head_ready0,
	output logic                                head_ready1,
	output logic                                head_exception0,
	output logic                                head_exception1,
	output logic                                head_halt0,
	output logic                                head_halt1,
	output logic                                head_store0,
	output logic                                head_store1,
	output logic [rob_pkg::ar_width-1:0]        head_ar0,
	output logic [rob_pkg::ar_width-1:0]        head_ar1,
	output logic [rob_pkg::tag_width-1:0]       head_tag0,
	output logic [rob_pkg::tag_width-1:0]       head_tag1,
	output logic [rob_pkg::tag_width-1:0]       head_told0,
	output logic [rob_pkg::tag_width-1:0]       head_told1
);

	logic [rob_pkg::rob_depth-1:0] valid;
	logic [rob_pkg::rob_depth-1:0] ready;
	logic [rob_pkg::rob_depth-1:0] exception;
	logic [rob_pkg::rob_depth-1:0] halt;
	logic [rob_pkg::rob_depth-1:0] store;
	logic [rob_pkg::ar_width-1:0]  ar   [rob_pkg::rob_depth];
	logic [rob_pkg::tag_width-1:0] tag  [rob_pkg::rob_depth];
	logic [rob_pkg::tag_width-1:0] told [rob_pkg::rob_depth];

	logic [rob_pkg::tag_width-1:0]       lane_tag [rob_pkg::cdb_lanes];
	logic [rob_pkg::cdb_lanes-1:0]       lane_exception;
	logic [rob_pkg::rob_depth-1:0]       hit;            // some lane matched this entry
	logic [rob_pkg::rob_depth-1:0]       hit_exception;
	logic [rob_pkg::rob_depth-1:0]       release_mask;
	logic [rob_pkg::rob_index_width-1:0] head_next;

	assign lane_tag[0]    = cdb_tag0;
	assign lane_tag[1]    = cdb_tag1;
	assign lane_exception = {cdb_exception1, cdb_exception0};
	assign head_next      = head + 1'b1;

	//////////////////////////////////////////////////
	// completion match and release
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < rob_pkg::rob_depth; i++)
		begin
			hit[i]           = 1'b0;
			hit_exception[i] = 1'b0;
			for (int l = 0; l < rob_pkg::cdb_lanes; l++)
			begin
				if (cdb_valid[l] && valid[i] && (tag[i] == lane_tag[l]))
				begin
					hit[i]           = 1'b1;
					hit_exception[i] = lane_exception[l];  // higher lane wins
				end
			end
		end
		release_mask = '0;
		if (retire_num != 2'd0)
			release_mask[head] = 1'b1;
		if (retire_num == 2'd2)
			release_mask[head_next] = 1'b1;
	end

	// valid, ready and tag
	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			valid <= '0;
			ready <= '0;
			for (int i = 0; i < rob_pkg::rob_depth; i++)
				tag[i] <= '1;
		end
		else
		begin
			ready <= ready | hit;
			for (int i = 0; i < rob_pkg::rob_depth; i++)
			begin
				if (release_mask[i])
				begin
					valid[i] <= 1'b0;
					ready[i] <= 1'b0;
					tag[i]   <= '1;
				end
			end
			if (write_enable0)
			begin
				valid[write_index0] <= 1'b1;
				ready[write_index0] <= ~valid_inst0 | halt0;  // nothing to wait for
				tag[write_index0]   <= new_tag0;
			end
			if (write_enable1)
			begin
				valid[write_index1] <= 1'b1;
				ready[write_index1] <= ~valid_inst1 | halt1;
				tag[write_index1]   <= new_tag1;
			end
		end
	end

	// payload fields
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < rob_pkg::rob_depth; i++)
		begin
			if (hit[i])
				exception[i] <= hit_exception[i];
		end
		if (write_enable0)
		begin
			exception[write_index0] <= 1'b0;
			halt[write_index0]      <= halt0;
			store[write_index0]     <= store0;
			ar[write_index0]        <= dest_ar0;
			told[write_index0]      <= old_tag0;
		end
		if (write_enable1)
		begin
			exception[write_index1] <= 1'b0;
			halt[write_index1]      <= halt1;
			store[write_index1]     <= store1;
			ar[write_index1]        <= dest_ar1;
			told[write_index1]      <= old_tag1;
		end
	end

	// read ports for the two oldest entries
	assign head_ready0     = ready[head];
	assign head_ready1     = ready[head_next];
	assign head_exception0 = exception[head];
	assign head_exception1 = exception[head_next];
	assign head_halt0      = halt[head];
	assign head_halt1      = halt[head_next];
	assign head_store0     = store[head];
	assign head_store1     = store[head_next];
	assign head_ar0        = ar[head];
	assign head_ar1        = ar[head_next];
	assign head_tag0       = tag[head];
	assign head_tag1       = tag[head_next];
	assign head_told0      = told[head];
	assign head_told1      = told[head_next];

endmodule

//--- rob_pkg.sv
//////////////////////////////////////////////////
// reorder buffer shared definitions
// sizes of the entry table and its indices
// physical tag and architectural register widths
// completion lane count and issue width
// retire decision type
//////////////////////////////////////////////////

package rob_pkg;

	//////////////////////////////////////////////////
	// table geometry
	//////////////////////////////////////////////////

	localparam int rob_depth       = 64;  // entries in the buffer
	localparam int rob_index_width = 6;   // head and tail index bits
	localparam int count_width     = 7;   // occupancy, reaches rob_depth

	//////////////////////////////////////////////////
	// register naming
	//////////////////////////////////////////////////

	localparam int tag_width = 7;  // physical register tag
	localparam int ar_width  = 5;  // architectural register index

	//////////////////////////////////////////////////
	// bandwidth
	//////////////////////////////////////////////////

	localparam int cdb_lanes      = 2;  // completion broadcast lanes
	localparam int dispatch_width = 2;  // max entries in or out per cycle

	// number of entries leaving the buffer this cycle
	typedef enum logic [1:0]
	{
		retire_none = 2'd0,
		retire_one  = 2'd1,
		retire_two  = 2'd2
	} retire_decision_t;

endpackage

//--- rob_properties.sv
//////////////////////////////////////////////////
// reorder buffer interface assertions
// capacity range and dispatch limit
// quiet cycle after a flush, halt at retire
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rob_properties
(
	input logic       clock,
	input logic       reset,
	input logic [1:0] capacity,
	input logic [1:0] dispatch_num,
	input logic [1:0] retire_num,
	input logic       flush,
	input logic       retire_halt
);

	int failure_count = 0;  // read by the testbench at the end

	capacity_range: assert property (@(posedge clock) disable iff (reset)
		capacity <= 2'd2)
		else
		begin
			failure_count++;
			$error("capacity above two");
		end

	dispatch_limit: assert property (@(posedge clock) disable iff (reset)
		dispatch_num <= capacity)
		else
		begin
			failure_count++;
			$error("dispatch_num above capacity");
		end

	empty_after_flush: assert property (@(posedge clock) disable iff (reset)
		flush |=> (retire_num == 2'd0))
		else
		begin
			failure_count++;
			$error("retirement in the cycle after a flush");
		end

	halt_retires: assert property (@(posedge clock) disable iff (reset)
		retire_halt |-> (retire_num != 2'd0))
		else
		begin
			failure_count++;
			$error("retire_halt without a retirement");
		end

endmodule

//--- rob_retire.sv
//////////////////////////////////////////////////
// reorder buffer retire side
// head pointer and retire decision
// retired field outputs
// exception flush and halt report
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rob_retire
(
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                head_ready0,
	input  logic                                head_ready1,
	input  logic                                head_exception0,
	input  logic                                head_exception1,
	input  logic                                head_halt0,
	input  logic                                head_halt1,
	input  logic                                head_store0,
	input  logic                                head_store1,
	input  logic [rob_pkg::ar_width-1:0]        head_ar0,
	input  logic [rob_pkg::ar_width-1:0]        head_ar1,
	input  logic [rob_pkg::tag_width-1:0]       head_tag0,
	input  logic [rob_pkg::tag_width-1:0]       head_tag1,
	input  logic [rob_pkg::tag_width-1:0]       head_told0,
	input  logic [rob_pkg::tag_width-1:0]       head_told1,
	output logic [rob_pkg::rob_index_width-1:0] head,
	output logic [1:0]                          retire_num,
	output logic [rob_pkg::ar_width-1:0]        retire_ar0,
	output logic [rob_pkg::ar_width-1:0]        retire_ar1,
	output logic [rob_pkg::tag_width-1:0]       retire_tag0,
	output logic [rob_pkg::tag_width-1:0]       retire_tag1,
	output logic [rob_pkg::tag_width-1:0]       retire_told0,
	output logic [rob_pkg::tag_width-1:0]       retire_told1,
	output logic                                retire_store0,
	output logic                                retire_store1,
	output logic                                retire_exception,
	output logic                                retire_halt,
	output logic                                flush
);

	rob_pkg::retire_decision_t decision;
	logic                      first_out;   // head entry leaves
	logic                      second_out;  // head+1 entry leaves

	always_comb
	begin
		if (head_ready0 && head_ready1 && !head_exception0 && !(head_store0 && head_store1))
			decision = rob_pkg::retire_two;
		else if (head_ready0)
			decision = rob_pkg::retire_one;  // fault, store pair or head+1 pending
		else
			decision = rob_pkg::retire_none;
	end

	assign retire_num = decision;
	assign first_out  = (decision != rob_pkg::retire_none);
	assign second_out = (decision == rob_pkg::retire_two);

	//////////////////////////////////////////////////
	// retire report
	//////////////////////////////////////////////////

	assign retire_ar0    = head_ar0;
	assign retire_ar1    = head_ar1;
	assign retire_tag0   = head_tag0;
	assign retire_tag1   = head_tag1;
	assign retire_told0  = head_told0;
	assign retire_told1  = head_told1;
	assign retire_store0 = head_store0;
	assign retire_store1 = head_store1;

	assign retire_exception = (first_out && head_exception0) || (second_out && head_exception1);
	assign retire_halt      = (first_out && head_halt0) || (second_out && head_halt1);
	assign flush            = retire_exception;  // empties the whole buffer

	always_ff @(posedge clock)
	begin
		if (reset)
			head <= '0;
		else
			head <= head + rob_pkg::rob_index_width'(retire_num);
	end

endmodule

//--- rob_top.sv
//////////////////////////////////////////////////
// reorder buffer top level
// dispatch side, entry table and retire side
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rob_top
(
	input  logic                          clock,
	input  logic                          reset,
	input  logic [1:0]                    dispatch_num,
	input  logic [rob_pkg::ar_width-1:0]  dest_ar0,
	input  logic [rob_pkg::ar_width-1:0]  dest_ar1,
	input  logic [rob_pkg::tag_width-1:0] new_tag0,
	input  logic [rob_pkg::tag_width-1:0] new_tag1,
	input  logic [rob_pkg::tag_width-1:0] old_tag0,
	input  logic [rob_pkg::tag_width-1:0] old_tag1,
	input  logic                          valid_inst0,
	input  logic                          valid_inst1,
	input  logic                          halt0,
	input  logic                          halt1,
	input  logic                          store0,
	input  logic                          store1,
	input  logic [rob_pkg::cdb_lanes-1:0] cdb_valid,
	input  logic [rob_pkg::tag_width-1:0] cdb_tag0,
	input  logic [rob_pkg::tag_width-1:0] cdb_tag1,
	input  logic                          cdb_exception0,
	input  logic                          cdb_exception1,
	output logic [1:0]                    capacity,
	output logic [1:0]                    retire_num,
	output logic [rob_pkg::ar_width-1:0]  retire_ar0,
	output logic [rob_pkg::ar_width-1:0]  retire_ar1,
	output logic [rob_pkg::tag_width-1:0] retire_tag0,
	output logic [rob_pkg::tag_width-1:0] retire_tag1,
	output logic [rob_pkg::tag_width-1:0] retire_told0,
	output logic [rob_pkg::tag_width-1:0] retire_told1,
	output logic                          retire_store0,
	output logic                          retire_store1,
	output logic                          retire_exception,
	output logic                          retire_halt,
	output logic                          flush
);

	logic [rob_pkg::rob_index_width-1:0] head;
	logic                                write_enable0;
	logic                                write_enable1;
	logic [rob_pkg::rob_index_width-1:0] write_index0;
	logic [rob_pkg::rob_index_width-1:0] write_index1;

	// oldest two entries, table to retire
	logic                          head_ready0;
	logic                          head_ready1;
	logic                          head_exception0;
	logic                          head_exception1;
	logic                          head_halt0;
	logic                          head_halt1;
	logic                          head_store0;
	logic                          head_store1;
	logic [rob_pkg::ar_width-1:0]  head_ar0;
	logic [rob_pkg::ar_width-1:0]  head_ar1;
	logic [rob_pkg::tag_width-1:0] head_tag0;
	logic [rob_pkg::tag_width-1:0] head_tag1;
	logic [rob_pkg::tag_width-1:0] head_told0;
	logic [rob_pkg::tag_width-1:0] head_told1;

	rob_dispatch dispatch
	(
		.clock, .reset, .dispatch_num, .retire_num, .flush, .head,
		.capacity, .write_enable0, .write_enable1, .write_index0, .write_index1
	);

	rob_entry_table entry_table
	(
		.clock, .reset,
		.write_enable0, .write_enable1, .write_index0, .write_index1,
		.dest_ar0, .dest_ar1, .new_tag0, .new_tag1, .old_tag0, .old_tag1,
		.valid_inst0, .valid_inst1, .halt0, .halt1, .store0, .store1,
		.cdb_valid, .cdb_tag0, .cdb_tag1, .cdb_exception0, .cdb_exception1,
		.head, .retire_num, .flush,
		.head_ready0, .head_ready1, .head_exception0, .head_exception1,
		.head_halt0, .head_halt1, .head_store0, .head_store1,
		.head_ar0, .head_ar1, .head_tag0, .head_tag1, .head_told0, .head_told1
	);

	rob_retire retire
	(
		.clock, .reset,
		.head_ready0, .head_ready1, .head_exception0, .head_exception1,
		.head_halt0, .head_halt1, .head_store0, .head_store1,
		.head_ar0, .head_ar1, .head_tag0, .head_tag1, .head_told0, .head_told1,
		.head, .retire_num,
		.retire_ar0, .retire_ar1, .retire_tag0, .retire_tag1,
		.retire_told0, .retire_told1, .retire_store0, .retire_store1,
		.retire_exception, .retire_halt, .flush
	);

endmodule

//--- tb_rob_top.sv
//////////////////////////////////////////////////
// reorder buffer testbench
// clock, reset, directed and random stimulus
// outstanding tag list for completions
// timeout, UUT, checker and assertion bind
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rob_top;

	localparam int reset_cycles      = 10;
	localparam int random_cycles     = 500;
	localparam int total_test_cycles = reset_cycles + 40 + 120 + 40 + 80 + 40 + random_cycles + 120;
	localparam int timeout_limit     = total_test_cycles + 200;

	logic                          clock;
	logic                          reset;
	logic [1:0]                    dispatch_num;
	logic [rob_pkg::ar_width-1:0]  dest_ar0;
	logic [rob_pkg::ar_width-1:0]  dest_ar1;
	logic [rob_pkg::tag_width-1:0] new_tag0;
	logic [rob_pkg::tag_width-1:0] new_tag1;
	logic [rob_pkg::tag_width-1:0] old_tag0;
	logic [rob_pkg::tag_width-1:0] old_tag1;
	logic                          valid_inst0;
	logic                          valid_inst1;
	logic                          halt0;
	logic                          halt1;
	logic                          store0;
	logic                          store1;
	logic [rob_pkg::cdb_lanes-1:0] cdb_valid;
	logic [rob_pkg::tag_width-1:0] cdb_tag0;
	logic [rob_pkg::tag_width-1:0] cdb_tag1;
	logic                          cdb_exception0;
	logic                          cdb_exception1;
	logic [1:0]                    capacity;
	logic [1:0]                    retire_num;
	logic [rob_pkg::ar_width-1:0]  retire_ar0;
	logic [rob_pkg::ar_width-1:0]  retire_ar1;
	logic [rob_pkg::tag_width-1:0] retire_tag0;
	logic [rob_pkg::tag_width-1:0] retire_tag1;
	logic [rob_pkg::tag_width-1:0] retire_told0;
	logic [rob_pkg::tag_width-1:0] retire_told1;
	logic                          retire_store0;
	logic                          retire_store1;
	logic                          retire_exception;
	logic                          retire_halt;
	logic                          flush;
	int                            error_count;
	int                            check_count;

	logic [rob_pkg::tag_width-1:0] pending [$];  // dispatched, not yet completed
	int                            occupancy;
	int                            next_tag;
	int                            cycle_count;
	int                            test_num;
	int                            errors_before;

	rob_top UUT (.*);
	rob_checker retire_check (.*);
	bind rob_top rob_properties props (.*);

	always #50 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
		begin
			$display("run did not finish within %0d cycles", timeout_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// one clock edge, tracking the occupancy the DUT holds after it
	task automatic advance();
		@(posedge clock);
		if (flush)
		begin
			occupancy = 0;
			pending.delete();
		end
		else
			occupancy = occupancy + int'(dispatch_num) - int'(retire_num);
		dispatch_num   <= 2'd0;
		cdb_valid      <= '0;
		cdb_exception0 <= 1'b0;
		cdb_exception1 <= 1'b0;
	endtask

	function automatic int room();
		return (occupancy > rob_pkg::rob_depth - 2) ? rob_pkg::rob_depth - occupancy : 2;
	endfunction

	task automatic put_entry(input int slot, input bit vi, input bit h, input bit st);
		logic [rob_pkg::tag_width-1:0] t;
		t        = rob_pkg::tag_width'(next_tag);
		next_tag = (next_tag + 1) % 127;  // all-ones is the released value
		if (slot == 0)
		begin
			dest_ar0    <= rob_pkg::ar_width'($urandom);
			new_tag0    <= t;
			old_tag0    <= rob_pkg::tag_width'($urandom);
			valid_inst0 <= vi;
			halt0       <= h;
			store0      <= st;
		end
		else
		begin
			dest_ar1    <= rob_pkg::ar_width'($urandom);
			new_tag1    <= t;
			old_tag1    <= rob_pkg::tag_width'($urandom);
			valid_inst1 <= vi;
			halt1       <= h;
			store1      <= st;
		end
		dispatch_num <= 2'(slot + 1);
		if (vi && !h)
			pending.push_back(t);
	endtask

	task automatic complete(input int lane, input int idx, input bit exc);
		logic [rob_pkg::tag_width-1:0] t;
		t = pending[idx];
		pending.delete(idx);
		if (lane == 0)
		begin
			cdb_tag0       <= t;
			cdb_exception0 <= exc;
		end
		else
		begin
			cdb_tag1       <= t;
			cdb_exception1 <= exc;
		end
		cdb_valid[lane] <= 1'b1;
	endtask

	task automatic fill_normal(input int n);
		int k;
		while (n > 0)
		begin
			advance();
			k = (room() < n) ? room() : n;
			for (int s = 0; s < k; s++)
				put_entry(s, 1'b1, 1'b0, 1'b0);
			n -= k;
		end
	endtask

	// complete everything outstanding until the buffer is empty
	task automatic drain(input bit shuffled);
		forever
		begin
			advance();
			if (occupancy == 0 && pending.size() == 0)
				break;
			for (int lane = 0; lane < 2; lane++)
				if (pending.size() > 0)
					complete(lane, shuffled ? $urandom_range(pending.size() - 1) : 0, 1'b0);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, error_count - errors_before);
		errors_before = error_count;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		int k;
		int roll;
		void'($urandom(39880));
		clock          = 0;
		reset          = 1;
		dispatch_num   = 0;
		cdb_valid      = 0;
		dest_ar0       = 0;
		dest_ar1       = 0;
		new_tag0       = 0;
		new_tag1       = 0;
		old_tag0       = 0;
		old_tag1       = 0;
		valid_inst0    = 0;
		valid_inst1    = 0;
		halt0          = 0;
		halt1          = 0;
		store0         = 0;
		store1         = 0;
		cdb_tag0       = 0;
		cdb_tag1       = 0;
		cdb_exception0 = 0;
		cdb_exception1 = 0;
		occupancy      = 0;
		next_tag       = 0;
		cycle_count    = 0;
		test_num       = 0;
		errors_before  = 0;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;

		fill_normal(rob_pkg::rob_depth);
		repeat (4) advance();  // full, nothing completes
		end_test("fill to zero capacity");

		drain(1'b1);
		end_test("out of order completion");

		advance();
		put_entry(0, 1'b1, 1'b0, 1'b1);
		put_entry(1, 1'b1, 1'b0, 1'b1);
		advance();
		put_entry(0, 1'b1, 1'b0, 1'b1);
		put_entry(1, 1'b1, 1'b0, 1'b0);
		drain(1'b0);  // in order, so both stores sit ready at the head
		end_test("store pairing");

		fill_normal(4);
		advance();
		complete(0, 0, 1'b1);  // oldest faults
		complete(1, 0, 1'b0);  // its neighbour is ready too
		drain(1'b0);
		fill_normal(4);
		drain(1'b1);
		end_test("exception flush");

		advance();
		put_entry(0, 1'b0, 1'b0, 1'b0);
		put_entry(1, 1'b1, 1'b1, 1'b0);
		advance();
		put_entry(0, 1'b1, 1'b1, 1'b0);
		put_entry(1, 1'b0, 1'b0, 1'b1);
		drain(1'b0);
		end_test("invalid and halt entries");

		repeat (random_cycles)
		begin
			advance();
			// completions only for tags already in the buffer
			for (int lane = 0; lane < 2; lane++)
				if (pending.size() > 0 && $urandom % 2 == 0)
					complete(lane, $urandom_range(pending.size() - 1), $urandom % 50 == 0);
			k = ($urandom % 4 != 0) ? room() : $urandom_range(room());
			for (int s = 0; s < k; s++)
			begin
				roll = $urandom % 100;
				put_entry(s, roll >= 5, roll >= 96, roll % 3 == 0);
			end
		end
		drain(1'b1);
		end_test("random traffic");

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", test_num,
			check_count, error_count, UUT.props.failure_count);
		if (error_count == 0 && UUT.props.failure_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
